//--- include/rs_settings.svh
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// ====================
// core sizing.
// ====================

`define RS_NUM_REGS    16    // architectural registers.
`define RS_NUM_ENTRIES 5     // one alu, one load, one store, two mult.
`define RS_XLEN        32

// ====================
// units.
// ====================

`define RS_MEM_WORDS   64    // lower half read by loads, upper half written by stores.
`define RS_MUL_STAGES  3

`endif

//--- hw/rs_pkg.sv
`default_nettype none

`include "rs_settings.svh"

package rs_pkg;

    typedef enum logic [6:0] {
        LOAD  = 7'b0000011,
        STORE = 7'b0100011,
        OP    = 7'b0110011,
        MADD  = 7'b1000011   // integer multiply in this core.
    } opcode_e;

    typedef enum logic [1:0] {
        ADD = 2'd0,
        SUB = 2'd1,
        XOR = 2'd2
    } alu_func_e;

    typedef enum logic [1:0] {
        FU_ALU   = 2'd0,
        FU_LOAD  = 2'd1,
        FU_STORE = 2'd2,
        FU_MULT  = 2'd3
    } fu_class_e;

    typedef logic [2:0] tag_t;   // entry + 1, zero when value present.
    typedef logic [$clog2(`RS_NUM_REGS)-1:0] reg_idx_t;
    typedef logic [`RS_XLEN-1:0] word_t;
    typedef logic [$clog2(`RS_MEM_WORDS)-1:0] mem_addr_t;

    typedef struct packed {
        logic      valid;
        opcode_e   opcode;
        alu_func_e func;
        reg_idx_t  dest;
        reg_idx_t  src1;
        reg_idx_t  src2;
        logic [11:0] imm;
    } dispatch_packet_t;

    typedef struct packed {
        tag_t  tag;
        word_t value;
    } operand_t;

    typedef struct packed {
        logic      valid;
        tag_t      tag;
        fu_class_e fu_class;
        alu_func_e func;
        reg_idx_t  dest;
        word_t     v1;
        word_t     v2;
        logic [11:0] imm;
    } issue_packet_t;

    typedef struct packed {
        logic     valid;
        tag_t     tag;
        reg_idx_t dest;
        word_t    value;
    } cdb_packet_t;

    typedef struct packed {
        logic      valid;
        mem_addr_t addr;
        word_t     data;
    } mem_write_t;

endpackage

`default_nettype wire

//--- hw/map_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module map_table (
    input  logic                                  clock,
    input  logic                                  reset,
    input  rs_pkg::dispatch_packet_t              dispatch,
    input  logic                                  dispatch_fire,
    input  rs_pkg::tag_t                          alloc_tag,
    input  rs_pkg::cdb_packet_t                   cdb,
    output rs_pkg::operand_t                      src1_op,
    output rs_pkg::operand_t                      src2_op,
    output logic [`RS_NUM_REGS-1:0][`RS_XLEN-1:0] reg_values
);

    rs_pkg::tag_t tags [`RS_NUM_REGS];

    // value or producer tag, with the bus result forwarded.
    function automatic rs_pkg::operand_t lookup(input rs_pkg::reg_idx_t r);
        rs_pkg::operand_t op;
        op.tag   = tags[r];
        op.value = reg_values[r];
        if (tags[r] != '0 && cdb.valid && cdb.tag == tags[r]) begin
            op.tag   = '0;
            op.value = cdb.value;
        end
        return op;
    endfunction

    always_comb begin
        src1_op = lookup(dispatch.src1);
        src2_op = lookup(dispatch.src2);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            reg_values <= '0;
            for (int r = 0; r < `RS_NUM_REGS; r++) begin
                tags[r] <= '0;
            end
        end else begin
            // write back only while the register still waits on this tag.
            if (cdb.valid && tags[cdb.dest] == cdb.tag) begin
                reg_values[cdb.dest] <= cdb.value;
                tags[cdb.dest]       <= '0;
            end
            if (dispatch_fire && dispatch.opcode != rs_pkg::STORE && dispatch.dest != '0) begin
                tags[dispatch.dest] <= alloc_tag;   // newest producer wins.
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rs.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module rs (
    input  logic                     clock,
    input  logic                     reset,
    input  rs_pkg::dispatch_packet_t dispatch,
    input  rs_pkg::operand_t         src1_op,
    input  rs_pkg::operand_t         src2_op,
    input  rs_pkg::cdb_packet_t      cdb,
    input  logic                     store_done,
    input  logic [3:0]               unit_ready,
    output logic                     stall,
    output logic                     dispatch_fire,
    output rs_pkg::tag_t             alloc_tag,
    output rs_pkg::issue_packet_t    issue_alu,
    output rs_pkg::issue_packet_t    issue_load,
    output rs_pkg::issue_packet_t    issue_store,
    output rs_pkg::issue_packet_t    issue_mult
);

    localparam int NE    = `RS_NUM_ENTRIES;
    localparam int IDX_W = $clog2(NE);

    function automatic rs_pkg::fu_class_e entry_class(input int idx);
        case (idx)
            0:       return rs_pkg::FU_ALU;
            1:       return rs_pkg::FU_LOAD;
            2:       return rs_pkg::FU_STORE;
            default: return rs_pkg::FU_MULT;
        endcase
    endfunction

    logic [NE-1:0]     busy;
    logic [NE-1:0]     issued;
    rs_pkg::tag_t      tag1 [NE];
    rs_pkg::tag_t      tag2 [NE];
    rs_pkg::word_t     val1 [NE];
    rs_pkg::word_t     val2 [NE];
    rs_pkg::reg_idx_t  dest [NE];
    rs_pkg::alu_func_e func [NE];
    logic [11:0]       imm  [NE];

    rs_pkg::fu_class_e     disp_class;
    logic                  has_free;
    logic [IDX_W-1:0]      alloc_idx;
    logic [NE-1:0]         ready;
    logic [3:0]            sel_found;
    logic [IDX_W-1:0]      sel_idx [4];
    rs_pkg::issue_packet_t issue_q [4];   // one per class.

    // ====================
    // allocation
    // ====================

    always_comb begin
        case (dispatch.opcode)
            rs_pkg::LOAD:  disp_class = rs_pkg::FU_LOAD;
            rs_pkg::STORE: disp_class = rs_pkg::FU_STORE;
            rs_pkg::MADD:  disp_class = rs_pkg::FU_MULT;
            default:       disp_class = rs_pkg::FU_ALU;
        endcase
    end

    always_comb begin
        has_free  = 1'b0;
        alloc_idx = '0;
        for (int i = NE - 1; i >= 0; i--) begin   // lowest free entry wins.
            if (!busy[i] && entry_class(i) == disp_class) begin
                has_free  = 1'b1;
                alloc_idx = IDX_W'(i);
            end
        end
    end

    assign stall         = !has_free;
    assign dispatch_fire = dispatch.valid && has_free;
    assign alloc_tag     = rs_pkg::tag_t'(alloc_idx) + 3'd1;

    // ====================
    // issue select
    // ====================

    always_comb begin
        for (int i = 0; i < NE; i++) begin
            ready[i] = busy[i] && !issued[i] && tag1[i] == '0 && tag2[i] == '0;
        end
        for (int c = 0; c < 4; c++) begin
            sel_found[c] = 1'b0;
            sel_idx[c]   = '0;
            for (int i = NE - 1; i >= 0; i--) begin
                if (ready[i] && int'(entry_class(i)) == c) begin
                    sel_found[c] = 1'b1;
                    sel_idx[c]   = IDX_W'(i);
                end
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy   <= '0;
            issued <= '0;
            for (int i = 0; i < NE; i++) begin
                tag1[i] <= '0;
                tag2[i] <= '0;
            end
            for (int c = 0; c < 4; c++) begin
                issue_q[c] <= '0;
            end
        end else begin
            for (int i = 0; i < NE; i++) begin
                if (cdb.valid && tag1[i] == cdb.tag) tag1[i] <= '0;   // wakeup.
                if (cdb.valid && tag2[i] == cdb.tag) tag2[i] <= '0;
                if (cdb.valid && cdb.tag == rs_pkg::tag_t'(i + 1)) begin
                    busy[i] <= 1'b0;
                end
                if (store_done && entry_class(i) == rs_pkg::FU_STORE) begin
                    busy[i] <= 1'b0;
                end
                if (dispatch_fire && alloc_idx == IDX_W'(i)) begin
                    busy[i]   <= 1'b1;
                    issued[i] <= 1'b0;
                    tag1[i]   <= src1_op.tag;
                    // loads have no second operand.
                    tag2[i]   <= (disp_class == rs_pkg::FU_LOAD) ? '0 : src2_op.tag;
                end
            end
            for (int c = 0; c < 4; c++) begin
                if (!issue_q[c].valid || unit_ready[c]) begin
                    issue_q[c].valid <= 1'b0;
                    if (sel_found[c]) begin
                        issued[sel_idx[c]] <= 1'b1;
                        issue_q[c] <= '{
                            valid:    1'b1,
                            tag:      rs_pkg::tag_t'(sel_idx[c]) + 3'd1,
                            fu_class: rs_pkg::fu_class_e'(c),
                            func:     func[sel_idx[c]],
                            dest:     dest[sel_idx[c]],
                            v1:       val1[sel_idx[c]],
                            v2:       val2[sel_idx[c]],
                            imm:      imm[sel_idx[c]]
                        };
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < NE; i++) begin
            if (dispatch_fire && alloc_idx == IDX_W'(i)) begin
                val1[i] <= src1_op.value;
                val2[i] <= src2_op.value;
                dest[i] <= dispatch.dest;
                func[i] <= dispatch.func;
                imm[i]  <= dispatch.imm;
            end else begin
                if (cdb.valid && tag1[i] == cdb.tag) val1[i] <= cdb.value;
                if (cdb.valid && tag2[i] == cdb.tag) val2[i] <= cdb.value;
            end
        end
    end

    assign issue_alu   = issue_q[int'(rs_pkg::FU_ALU)];
    assign issue_load  = issue_q[int'(rs_pkg::FU_LOAD)];
    assign issue_store = issue_q[int'(rs_pkg::FU_STORE)];
    assign issue_mult  = issue_q[int'(rs_pkg::FU_MULT)];

endmodule

`default_nettype wire

//--- hw/exec_units.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module exec_units (
    input  logic                  clock,
    input  logic                  reset,
    input  rs_pkg::issue_packet_t issue_alu,
    input  rs_pkg::issue_packet_t issue_load,
    input  rs_pkg::issue_packet_t issue_store,
    input  rs_pkg::issue_packet_t issue_mult,
    input  logic [2:0]            grant,        // {mult, load, alu}.
    output logic [3:0]            unit_ready,   // indexed by fu class.
    output rs_pkg::cdb_packet_t   alu_result,
    output rs_pkg::cdb_packet_t   load_result,
    output rs_pkg::cdb_packet_t   mult_result,
    output logic                  store_done,
    output rs_pkg::mem_write_t    mem_write
);

    localparam int HALF_W = $clog2(`RS_MEM_WORDS) - 1;
    localparam int NSTAGE = `RS_MUL_STAGES;

    rs_pkg::word_t         mem [`RS_MEM_WORDS];
    rs_pkg::issue_packet_t load_s1;
    rs_pkg::cdb_packet_t   mul_pipe [NSTAGE];
    rs_pkg::word_t         alu_value;
    rs_pkg::word_t         mul_product;
    rs_pkg::mem_addr_t     load_addr;
    rs_pkg::mem_addr_t     store_addr;
    logic                  load_adv;
    logic                  mul_adv;

    // base plus imm, modulo half the memory.
    function automatic logic [HALF_W-1:0] half_addr(input rs_pkg::word_t base,
                                                    input logic [11:0] offset);
        rs_pkg::word_t sum;
        sum = base + {{(`RS_XLEN-12){offset[11]}}, offset};
        return sum[HALF_W-1:0];
    endfunction

    assign load_adv = !load_result.valid || grant[1];
    assign mul_adv  = !mul_pipe[NSTAGE-1].valid || grant[2];   // freeze while held.

    assign unit_ready[0] = !alu_result.valid || grant[0];
    assign unit_ready[1] = !load_s1.valid || load_adv;
    assign unit_ready[2] = 1'b1;
    assign unit_ready[3] = mul_adv;

    // ====================
    // alu
    // ====================

    always_comb begin
        case (issue_alu.func)
            rs_pkg::SUB: alu_value = issue_alu.v1 - issue_alu.v2;
            rs_pkg::XOR: alu_value = issue_alu.v1 ^ issue_alu.v2;
            default:     alu_value = issue_alu.v1 + issue_alu.v2;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_result <= '0;
        end else if (unit_ready[0]) begin
            alu_result <= '{
                valid: issue_alu.valid,
                tag:   issue_alu.tag,
                dest:  issue_alu.dest,
                value: alu_value
            };
        end
    end

    // ====================
    // load / store
    // ====================

    assign load_addr  = {1'b0, half_addr(load_s1.v1, load_s1.imm)};
    assign store_addr = {1'b1, half_addr(issue_store.v1, issue_store.imm)};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            load_s1     <= '0;
            load_result <= '0;
        end else begin
            if (load_adv) begin
                load_result <= '{
                    valid: load_s1.valid,
                    tag:   load_s1.tag,
                    dest:  load_s1.dest,
                    value: mem[load_addr]
                };
            end
            if (unit_ready[1]) load_s1 <= issue_load;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RS_MEM_WORDS; i++) begin
                if (i < `RS_MEM_WORDS / 2) begin
                    mem[i] <= rs_pkg::word_t'(i * 3);   // preload.
                end else begin
                    mem[i] <= '0;
                end
            end
            mem_write <= '0;
        end else begin
            mem_write.valid <= 1'b0;
            if (issue_store.valid) begin
                mem[store_addr] <= issue_store.v2;
                mem_write <= '{valid: 1'b1, addr: store_addr, data: issue_store.v2};
            end
        end
    end

    assign store_done = mem_write.valid;

    // ====================
    // multiply
    // ====================

    assign mul_product = issue_mult.v1 * issue_mult.v2;   // low word kept.

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < NSTAGE; s++) begin
                mul_pipe[s] <= '0;
            end
        end else if (mul_adv) begin
            mul_pipe[0] <= '{
                valid: issue_mult.valid,
                tag:   issue_mult.tag,
                dest:  issue_mult.dest,
                value: mul_product
            };
            for (int s = 1; s < NSTAGE; s++) begin
                mul_pipe[s] <= mul_pipe[s-1];
            end
        end
    end

    assign mult_result = mul_pipe[NSTAGE-1];

endmodule

`default_nettype wire

//--- hw/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    input  rs_pkg::cdb_packet_t alu_result,
    input  rs_pkg::cdb_packet_t load_result,
    input  rs_pkg::cdb_packet_t mult_result,
    output logic [2:0]          grant,   // {mult, load, alu}.
    output rs_pkg::cdb_packet_t cdb
);

    // fixed priority, mult over load over alu.
    always_comb begin
        grant = 3'b000;
        cdb   = '0;
        if (mult_result.valid) begin
            grant = 3'b100;
            cdb   = mult_result;
        end else if (load_result.valid) begin
            grant = 3'b010;
            cdb   = load_result;
        end else if (alu_result.valid) begin
            grant = 3'b001;
            cdb   = alu_result;
        end
    end

endmodule

`default_nettype wire

//--- hw/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module ooo_core_top (
    input  logic                                  clock,
    input  logic                                  reset,
    input  rs_pkg::dispatch_packet_t              dispatch,
    output logic                                  stall,
    output rs_pkg::cdb_packet_t                   cdb,
    output rs_pkg::mem_write_t                    mem_write,
    output logic [`RS_NUM_REGS-1:0][`RS_XLEN-1:0] reg_values
);

    rs_pkg::operand_t      src1_op;
    rs_pkg::operand_t      src2_op;
    logic                  dispatch_fire;
    rs_pkg::tag_t          alloc_tag;
    logic                  store_done;
    logic [3:0]            unit_ready;
    logic [2:0]            grant;
    rs_pkg::issue_packet_t issue_alu;
    rs_pkg::issue_packet_t issue_load;
    rs_pkg::issue_packet_t issue_store;
    rs_pkg::issue_packet_t issue_mult;
    rs_pkg::cdb_packet_t   alu_result;
    rs_pkg::cdb_packet_t   load_result;
    rs_pkg::cdb_packet_t   mult_result;

    map_table u_map_table (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .dispatch_fire (dispatch_fire),
        .alloc_tag     (alloc_tag),
        .cdb           (cdb),
        .src1_op       (src1_op),
        .src2_op       (src2_op),
        .reg_values    (reg_values)
    );

    rs u_rs (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .src1_op       (src1_op),
        .src2_op       (src2_op),
        .cdb           (cdb),
        .store_done    (store_done),
        .unit_ready    (unit_ready),
        .stall         (stall),
        .dispatch_fire (dispatch_fire),
        .alloc_tag     (alloc_tag),
        .issue_alu     (issue_alu),
        .issue_load    (issue_load),
        .issue_store   (issue_store),
        .issue_mult    (issue_mult)
    );

    exec_units u_exec_units (
        .clock       (clock),
        .reset       (reset),
        .issue_alu   (issue_alu),
        .issue_load  (issue_load),
        .issue_store (issue_store),
        .issue_mult  (issue_mult),
        .grant       (grant),
        .unit_ready  (unit_ready),
        .alu_result  (alu_result),
        .load_result (load_result),
        .mult_result (mult_result),
        .store_done  (store_done),
        .mem_write   (mem_write)
    );

    cdb_arbiter u_cdb_arbiter (
        .alu_result  (alu_result),
        .load_result (load_result),
        .mult_result (mult_result),
        .grant       (grant),
        .cdb         (cdb)
    );

endmodule

`default_nettype wire

//--- verification/ooo_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module ooo_tb;

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 20;
    localparam int NE             = `RS_NUM_ENTRIES;
    localparam int HALF_WORDS     = `RS_MEM_WORDS / 2;
    localparam int STORE_ENTRY    = 2;

    logic                                  clock;
    logic                                  reset;
    rs_pkg::dispatch_packet_t              dispatch;
    logic                                  stall;
    rs_pkg::cdb_packet_t                   cdb;
    rs_pkg::mem_write_t                    mem_write;
    logic [`RS_NUM_REGS-1:0][`RS_XLEN-1:0] reg_values;

    // ====================
    // reference model state
    // ====================

    rs_pkg::word_t      model_regs  [`RS_NUM_REGS];
    logic [NE-1:0]      model_busy;
    logic               exp_pending [1:NE];   // keyed by tag.
    rs_pkg::reg_idx_t   exp_dest    [1:NE];
    rs_pkg::word_t      exp_value   [1:NE];
    rs_pkg::mem_write_t store_q     [$];
    int                 accepted;
    int                 cycle_count = 0;

    ooo_core_top dut_i (
        .clock      (clock),
        .reset      (reset),
        .dispatch   (dispatch),
        .stall      (stall),
        .cdb        (cdb),
        .mem_write  (mem_write),
        .reg_values (reg_values)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string what);
        fail_now($sformatf("Mismatch at %0t ns: %s", $time, what));
    endtask

    always @(posedge clock) begin
        if (!reset) begin
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                fail_now($sformatf("Timeout: no completion within %0d cycles, the DUT hangs",
                                   TIMEOUT_CYCLES));
            end
        end
    end

    // ====================
    // compare tasks
    // ====================

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("stall %b, expected %b for opcode %s",
                                      got, exp, dispatch.opcode.name()));
        end
    endtask

    task automatic check_cdb(input rs_pkg::cdb_packet_t got);
        int t;
        t = int'(got.tag);
        if (t < 1 || t > NE || !exp_pending[t]) begin
            fail_now($sformatf("CDB broadcast at %0t ns for tag %0d with no instruction in flight",
                               $time, t));
        end else begin
            if (got.dest !== exp_dest[t] || got.value !== exp_value[t]) begin
                report_mismatch($sformatf("cdb tag %0d dest %0d value %h, expected dest %0d value %h",
                                          t, got.dest, got.value, exp_dest[t], exp_value[t]));
            end
            exp_pending[t]  = 1'b0;
            model_busy[t-1] = 1'b0;
        end
    endtask

    task automatic check_store(input rs_pkg::mem_write_t got);
        rs_pkg::mem_write_t exp;
        if (store_q.size() == 0) begin
            fail_now($sformatf("memory write at %0t ns with no store in flight", $time));
        end else begin
            exp = store_q.pop_front();
            if (got.addr !== exp.addr || got.data !== exp.data) begin
                report_mismatch($sformatf("store addr %0d data %h, expected addr %0d data %h",
                                          got.addr, got.data, exp.addr, exp.data));
            end
            model_busy[STORE_ENTRY] = 1'b0;
        end
    endtask

    task automatic check_regs(input logic [`RS_NUM_REGS-1:0][`RS_XLEN-1:0] got);
        for (int r = 0; r < `RS_NUM_REGS; r++) begin
            if (got[r] !== model_regs[r]) begin
                report_mismatch($sformatf("x%0d is %h, expected %h", r, got[r], model_regs[r]));
            end
        end
    endtask

    // ====================
    // model
    // ====================

    function automatic int first_entry(input rs_pkg::opcode_e op);
        case (op)
            rs_pkg::LOAD:  return 1;
            rs_pkg::STORE: return 2;
            rs_pkg::MADD:  return 3;
            default:       return 0;
        endcase
    endfunction

    // lowest free entry of the class, -1 when full.
    function automatic int find_free(input rs_pkg::opcode_e op);
        int first;
        int last;
        int idx;
        first = first_entry(op);
        last  = (op == rs_pkg::MADD) ? first + 1 : first;
        idx   = -1;
        for (int e = last; e >= first; e--) begin
            if (!model_busy[e]) idx = e;
        end
        return idx;
    endfunction

    // executes in program order at acceptance.
    task automatic accept_instr(input rs_pkg::dispatch_packet_t p, input int entry);
        rs_pkg::word_t      a;
        rs_pkg::word_t      b;
        rs_pkg::word_t      sum;
        rs_pkg::word_t      res;
        rs_pkg::mem_write_t w;
        int                 tag;
        a   = model_regs[p.src1];
        b   = model_regs[p.src2];
        sum = a + rs_pkg::word_t'(p.imm);   // only the low bits matter.
        res = '0;
        tag = entry + 1;
        case (p.opcode)
            rs_pkg::STORE: begin
                w.valid = 1'b1;
                w.addr  = rs_pkg::mem_addr_t'(sum % HALF_WORDS + HALF_WORDS);
                w.data  = b;
                store_q.push_back(w);
            end
            rs_pkg::LOAD: res = (sum % HALF_WORDS) * 3;   // preloaded word.
            rs_pkg::MADD: res = a * b;
            default: begin
                case (p.func)
                    rs_pkg::SUB: res = a - b;
                    rs_pkg::XOR: res = a ^ b;
                    default:     res = a + b;
                endcase
            end
        endcase
        if (p.opcode != rs_pkg::STORE) begin
            exp_pending[tag] = 1'b1;
            exp_dest[tag]    = p.dest;
            exp_value[tag]   = res;
            if (p.dest != '0) model_regs[p.dest] = res;
        end
        model_busy[entry] = 1'b1;
        accepted++;
    endtask

    function automatic rs_pkg::dispatch_packet_t random_instr(input rs_pkg::dispatch_packet_t prev);
        rs_pkg::dispatch_packet_t p;
        int unsigned pick;
        p.valid = 1'b1;
        pick    = $urandom_range(0, 99);
        if (prev.valid && prev.opcode == rs_pkg::MADD && pick < 50) begin
            p.opcode = rs_pkg::MADD;   // back-to-back multiplies.
        end else begin
            pick = $urandom_range(0, 99);
            if (pick < 30)      p.opcode = rs_pkg::LOAD;
            else if (pick < 65) p.opcode = rs_pkg::OP;
            else if (pick < 85) p.opcode = rs_pkg::MADD;
            else                p.opcode = rs_pkg::STORE;
        end
        p.func = rs_pkg::alu_func_e'(2'($urandom_range(0, 2)));
        p.dest = rs_pkg::reg_idx_t'($urandom_range(0, `RS_NUM_REGS - 1));
        p.src1 = rs_pkg::reg_idx_t'($urandom_range(0, `RS_NUM_REGS - 1));
        p.src2 = rs_pkg::reg_idx_t'($urandom_range(0, `RS_NUM_REGS - 1));
        if (prev.valid && $urandom_range(0, 1) == 1) p.src1 = prev.dest;   // dependent chain.
        p.imm = 12'($urandom);
        return p;
    endfunction

    // one cycle of checks, as seen just before the next rising edge.
    task automatic observe_cycle(output logic taken);
        int   entry;
        logic exp_stall;
        entry     = find_free(dispatch.opcode);
        exp_stall = (entry < 0);
        check_stall(stall, exp_stall);
        taken = dispatch.valid && !exp_stall;
        if (cdb.valid) check_cdb(cdb);
        if (mem_write.valid) check_store(mem_write);
        if (taken) accept_instr(dispatch, entry);
    endtask

    // ====================
    // stimulus
    // ====================

    initial begin
        rs_pkg::dispatch_packet_t cur;
        rs_pkg::dispatch_packet_t prev;
        logic                     pending;
        logic                     taken;
        void'($urandom(65));
        reset      = 1'b1;
        dispatch   = '0;
        model_busy = '0;
        accepted   = 0;
        for (int r = 0; r < `RS_NUM_REGS; r++) model_regs[r] = '0;
        for (int t = 1; t <= NE; t++) exp_pending[t] = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset   = 1'b0;
        pending = 1'b0;
        prev    = '0;
        cur     = '0;

        while (accepted < NUM_INSTR) begin
            if (!pending) begin
                cur = random_instr(prev);
                if ($urandom_range(0, 7) == 0) begin
                    cur.valid = 1'b0;   // idle cycle.
                end else begin
                    prev    = cur;
                    pending = 1'b1;
                end
            end
            dispatch = cur;   // a stalled packet is driven again.
            #1;
            observe_cycle(taken);
            if (taken) pending = 1'b0;
            @(negedge clock);
        end

        dispatch.valid = 1'b0;
        while (model_busy != '0) begin
            #1;
            observe_cycle(taken);
            @(negedge clock);
        end
        repeat (4) begin   // no stray broadcasts after drain.
            #1;
            observe_cycle(taken);
            @(negedge clock);
        end
        #1;
        check_regs(reg_values);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
hw/rs_pkg.sv
hw/map_table.sv
hw/rs.sv
hw/exec_units.sv
hw/cdb_arbiter.sv
hw/ooo_core_top.sv
verification/ooo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line in the log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    -f vlog.f --top-module ooo_tb -o ooo_sim \
    && ./obj_dir/ooo_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "run_sim: build or simulation failed"; exit 1; }

cat sim.log
grep -q "Simulation PASSED" sim.log \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }
